// File: bench/gat_ref_model.svh
`ifndef GAT_REF_MODEL_SVH
`define GAT_REF_MODEL_SVH

// Reads the testbench memory arrays directly

function automatic int weight_ref(input int o, input int i);
  return int'(wgt_mem[o * `GAT_F_IN + i]);
endfunction

// One WH row from len consecutive sparse entries
function automatic wh_row_t wh_row_ref(input int base, input int len);
  wh_row_t  row;
  h_entry_t ent;
  int       sum;
  for (int o = 0; o < `GAT_F_OUT; o++) begin
    sum = 0;
    for (int k = 0; k < len; k++) begin
      ent = h_mem[base + k];
      sum += int'(ent.value) * weight_ref(o, int'(ent.col));
    end
    row[o] = wh_elem_t'(sum);
  end
  return row;
endfunction

// Score against target node 0, leaky ReLU, scale, clamp to a signed byte
function automatic coef_t coef_ref(input wh_row_t wh_tgt, input wh_row_t wh_nb);
  longint score;
  longint scaled;
  coef_t  c;
  score = 0;
  for (int o = 0; o < `GAT_F_OUT; o++) begin
    score += longint'(wgt_mem[`GAT_F_IN * `GAT_F_OUT + o]) * longint'($signed(wh_tgt[o]));
    score += longint'(wgt_mem[`GAT_F_IN * `GAT_F_OUT + `GAT_F_OUT + o])
             * longint'($signed(wh_nb[o]));
  end
  if (score < 0) begin
    score = score >>> `GAT_LRELU_SHIFT;
  end
  scaled = score >>> `GAT_COEF_SHIFT;
  if (scaled > 127) begin
    c = 8'sd127;
  end else if (scaled < -128) begin
    c = -8'sd128;
  end else begin
    c = coef_t'(scaled);
  end
  return c;
endfunction

// Expected feature vector of one subgraph
function automatic feat_vec_t feat_ref(input int node_base, input int h_base, input int nodes);
  feat_vec_t acc;
  wh_row_t   rows [`GAT_MAX_NODES];
  coef_t     c;
  int        hp;
  acc = '0;
  hp  = h_base;
  for (int j = 0; j < nodes; j++) begin
    rows[j] = wh_row_ref(hp, int'(info_mem[node_base + j].row_len));
    hp += int'(info_mem[node_base + j].row_len);
  end
  for (int j = 0; j < nodes; j++) begin
    c = coef_ref(rows[0], rows[j]);
    for (int o = 0; o < `GAT_F_OUT; o++) begin
      acc[o] = feat_t'(int'($signed(acc[o])) + int'(c) * int'($signed(rows[j][o])));
    end
  end
  return acc;
endfunction

`endif

// File: bench/gat_layer_tb.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module gat_layer_tb import gat_pkg::*; ();

  localparam int NUM_SG  = 6;
  localparam int WDEPTH  = `GAT_WEIGHT_DEPTH;
  localparam int TIMEOUT = 100 + NUM_SG * 2 * `GAT_MAX_NODES * (`GAT_F_IN + 8);
  // Mixed node counts, subgraphs 3 and 4 carry full rows back to back
  localparam int SG_NODES [NUM_SG] = '{1, 4, 2, 4, 4, 3};

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        start;
  logic                        wgt_load_done;
  logic [`GAT_SG_W-1:0]        num_sg;
  logic [$clog2(WDEPTH)-1:0]   wgt_addr;
  data_t                       wgt_data = '0;
  logic [`GAT_NODE_ADDR_W-1:0] info_addr;
  node_info_t                  info_data = '0;
  logic [`GAT_H_ADDR_W-1:0]    h_addr;
  h_entry_t                    h_data = '0;
  logic                        feat_vld;
  feat_vec_t                   feat;
  logic [`GAT_SG_W-1:0]        feat_sg;
  logic                        done;

  data_t      wgt_mem  [WDEPTH];
  node_info_t info_mem [1 << `GAT_NODE_ADDR_W];
  h_entry_t   h_mem    [1 << `GAT_H_ADDR_W];

  feat_vec_t exp_q [$];
  logic      exp_done;
  int        seed = 23261;
  int        seen;
  int        cycle_cnt;

  `include "gat_ref_model.svh"

  gat_layer uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start),
    .num_sg_i        (num_sg),
    .wgt_addr_o      (wgt_addr),
    .wgt_data_i      (wgt_data),
    .wgt_load_done_i (wgt_load_done),
    .info_addr_o     (info_addr),
    .info_data_i     (info_data),
    .h_addr_o        (h_addr),
    .h_data_i        (h_data),
    .feat_vld_o      (feat_vld),
    .feat_o          (feat),
    .feat_sg_o       (feat_sg),
    .done_o          (done)
  );

  always #20 clk = ~clk;

  // Synchronous memories, one cycle read latency
  always @(posedge clk) begin
    wgt_data  <= wgt_mem[wgt_addr];
    info_data <= info_mem[info_addr];
    h_data    <= h_mem[h_addr];
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_feat(input feat_vec_t got, input logic [`GAT_SG_W-1:0] got_sg,
                            input feat_vec_t exp, input logic [`GAT_SG_W-1:0] exp_sg);
    if (got_sg !== exp_sg) begin
      stop_on_error($sformatf("MISMATCH at %0t: feat_sg_o is %0d, expected %0d",
                              $time, got_sg, exp_sg));
    end
    for (int o = 0; o < `GAT_F_OUT; o++) begin
      if (got[o] !== exp[o]) begin
        stop_on_error($sformatf("MISMATCH at %0t: subgraph %0d feature %0d is %0d, expected %0d",
                                $time, exp_sg, o, $signed(got[o]), $signed(exp[o])));
      end
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: done_o is %0b, expected %0b", $time, got, exp));
    end
  endtask

  task automatic build_stimulus();
    node_info_t ni;
    h_entry_t   he;
    int         node_base;
    int         h_base;
    int         sg_h_base;
    int         len;
    node_base = 0;
    h_base    = 0;
    for (int i = 0; i < WDEPTH; i++) begin
      wgt_mem[i] = data_t'($random(seed));
    end
    for (int sg = 0; sg < NUM_SG; sg++) begin
      sg_h_base = h_base;
      for (int j = 0; j < SG_NODES[sg]; j++) begin
        if (sg == 0) begin
          len = 1;
        end else if (sg == 1) begin
          len = (j == 0) ? 0 : (j == 1) ? 8 : (j == 2) ? 5 : 3;
        end else if (sg == 3 || sg == 4) begin
          len = `GAT_F_IN;
        end else begin
          len = {$random(seed)} % (`GAT_F_IN + 1);
        end
        ni.row_len  = len;
        ni.node_cnt = SG_NODES[sg];
        ni.last     = (j == SG_NODES[sg] - 1);
        info_mem[node_base + j] = ni;
        for (int k = 0; k < len; k++) begin
          // Repeated columns on the full row of subgraph 1
          he.col = (sg == 1 && j == 1) ? k % 3 : $random(seed);
          // Small values keep odd subgraphs out of saturation
          he.value = (sg % 2 == 1) ? data_t'($random(seed) % 4) : data_t'($random(seed));
          h_mem[h_base + k] = he;
        end
        h_base += len;
      end
      exp_q.push_back(feat_ref(node_base, sg_h_base, SG_NODES[sg]));
      node_base += SG_NODES[sg];
    end
  endtask

  // Outputs sampled on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_done(done, exp_done);
      if (feat_vld) begin
        if (exp_q.size() == 0) begin
          stop_on_error($sformatf("Unexpected extra feature vector for subgraph %0d at %0t",
                                  feat_sg, $time));
        end else begin
          check_feat(feat, feat_sg, exp_q.pop_front(), seen[`GAT_SG_W-1:0]);
          seen++;
          if (seen == NUM_SG) begin
            exp_done = 1'b1;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n         = 1'b0;
    start         = 1'b0;
    wgt_load_done = 1'b0;
    num_sg        = NUM_SG;
    exp_done      = 1'b0;
    seen          = 0;
    cycle_cnt     = 0;
    build_stimulus();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    start <= 1'b1;
    repeat (3) @(posedge clk);
    wgt_load_done <= 1'b1;
    while (!exp_done) begin
      @(posedge clk);
    end
    // done_o has to hold while start is high
    repeat (6) @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    exp_done = 1'b0;
    repeat (4) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: gat_layer.f
+incdir+include
+incdir+bench
rtl/gat_pkg.sv
rtl/weight_loader.sv
rtl/wh_engine.sv
rtl/coef_engine.sv
rtl/coef_fifo.sv
rtl/wh_mem_arbiter.sv
rtl/aggregator.sv
rtl/gat_layer.sv
bench/gat_layer_tb.sv

// File: include/gat_defines.svh
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// Layer dimensions
`define GAT_F_IN          8
`define GAT_F_OUT         4
`define GAT_MAX_NODES     4

// Datapath widths
`define GAT_DATA_W        8
`define GAT_COL_W         3
`define GAT_WH_W          20
`define GAT_SCORE_W       32
`define GAT_FEAT_W        32
`define GAT_SG_W          8

// Coefficient quantization
`define GAT_COEF_SHIFT    10
`define GAT_LRELU_SHIFT   3

// W matrix followed by a_hi and a_lo
`define GAT_WEIGHT_DEPTH  (`GAT_F_IN * `GAT_F_OUT + 2 * `GAT_F_OUT)
`define GAT_H_ADDR_W      12
`define GAT_NODE_ADDR_W   10
`define GAT_COEF_DEPTH    8

`endif

// File: rtl/aggregator.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module aggregator import gat_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  logic                 sg_done_i,
  input  logic                 sg_bank_i,
  input  node_cnt_t            node_cnt_i,
  input  logic                 rd_gnt_i,
  input  wh_row_t              rd_data_i,
  input  coef_t                coef_i,
  input  logic                 coef_empty_i,
  input  logic [`GAT_SG_W-1:0] num_sg_i,
  output logic                 rd_req_o,
  output logic                 rd_bank_o,
  output slot_t                rd_slot_o,
  output logic                 coef_rd_o,
  output logic                 bank_release_o,
  output feat_vec_t            feat_o,
  output logic                 feat_vld_o,
  output logic [`GAT_SG_W-1:0] feat_sg_o,
  output logic                 done_o
);

  aggr_state_e state;
  logic [1:0]  pend;
  node_cnt_t   cnt_q [2];
  node_cnt_t   cur_cnt;
  coef_t       coef_r;

  // Only ask for a row once its coefficient is queued
  assign rd_req_o       = (state == AG_READ) && !coef_empty_i;
  assign coef_rd_o      = rd_req_o && rd_gnt_i;
  assign feat_vld_o     = (state == AG_EMIT);
  assign bank_release_o = (state == AG_EMIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= AG_IDLE;
      pend      <= 2'b00;
      rd_bank_o <= 1'b0;
      rd_slot_o <= '0;
      feat_sg_o <= '0;
      done_o    <= 1'b0;
    end else begin
      if (sg_done_i) begin
        pend[sg_bank_i] <= 1'b1;
      end
      case (state)
        AG_IDLE: begin
          if (!start_i) begin
            rd_bank_o <= 1'b0;
            feat_sg_o <= '0;
            done_o    <= 1'b0;
          end else if (pend[rd_bank_o]) begin
            pend[rd_bank_o] <= 1'b0;
            rd_slot_o       <= '0;
            state           <= AG_READ;
          end
        end
        AG_READ: begin
          if (coef_rd_o) begin
            state <= AG_ACCUM;
          end
        end
        AG_ACCUM: begin
          if (rd_slot_o == slot_t'(cur_cnt - 1'b1)) begin
            state <= AG_EMIT;
          end else begin
            rd_slot_o <= rd_slot_o + 1'b1;
            state     <= AG_READ;
          end
        end
        AG_EMIT: begin
          rd_bank_o <= !rd_bank_o;
          feat_sg_o <= feat_sg_o + 1'b1;
          if (feat_sg_o + 1'b1 == num_sg_i) begin
            done_o <= 1'b1;
          end
          state <= AG_IDLE;
        end
        default: state <= AG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sg_done_i) begin
      cnt_q[sg_bank_i] <= node_cnt_i;
    end
    if ((state == AG_IDLE) && pend[rd_bank_o]) begin
      cur_cnt <= cnt_q[rd_bank_o];
      feat_o  <= '0;
    end
    if (coef_rd_o) begin
      coef_r <= coef_i;
    end
    // Row data is back one cycle after the grant
    if (state == AG_ACCUM) begin
      for (int o = 0; o < `GAT_F_OUT; o++) begin
        feat_o[o] <= $signed(feat_o[o]) + $signed(coef_r) * $signed(rd_data_i[o]);
      end
    end
  end

  // A bank is never completed again while still queued
  a_queue : assert property (@(posedge clk) disable iff (!rst_n)
    sg_done_i |-> !pend[sg_bank_i]);

endmodule

// File: rtl/coef_engine.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module coef_engine import gat_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  attn_vec_t attn_i,
  input  wh_row_t   row_i,
  input  logic      row_vld_i,
  input  logic      row_last_i,
  output coef_t     coef_o,
  output logic      coef_wr_o
);

  localparam int SW = `GAT_SCORE_W;
  localparam logic signed [SW-1:0] SAT_MAX = SW'(127);
  localparam logic signed [SW-1:0] SAT_MIN = -SW'(128);

  logic signed [SW-1:0] dot_hi;
  logic signed [SW-1:0] dot_lo;
  logic signed [SW-1:0] self_hi;
  logic signed [SW-1:0] score;
  logic signed [SW-1:0] relu;
  logic signed [SW-1:0] scaled;
  coef_t                sat;
  logic                 first;
  logic                 s1_vld;

  always_comb begin
    dot_hi = '0;
    dot_lo = '0;
    for (int o = 0; o < `GAT_F_OUT; o++) begin
      dot_hi = dot_hi + $signed(attn_i.a_hi[o]) * $signed(row_i[o]);
      dot_lo = dot_lo + $signed(attn_i.a_lo[o]) * $signed(row_i[o]);
    end
  end

  // Leaky ReLU, scale down, clamp to a byte
  always_comb begin
    relu   = score[SW-1] ? (score >>> `GAT_LRELU_SHIFT) : score;
    scaled = relu >>> `GAT_COEF_SHIFT;
    if (scaled > SAT_MAX) begin
      sat = SAT_MAX[`GAT_DATA_W-1:0];
    end else if (scaled < SAT_MIN) begin
      sat = SAT_MIN[`GAT_DATA_W-1:0];
    end else begin
      sat = scaled[`GAT_DATA_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first     <= 1'b1;
      s1_vld    <= 1'b0;
      coef_wr_o <= 1'b0;
    end else begin
      s1_vld    <= row_vld_i;
      coef_wr_o <= s1_vld;
      if (row_vld_i) begin
        first <= row_last_i;
      end
    end
  end

  // Target node term is taken from the first row
  always_ff @(posedge clk) begin
    if (row_vld_i) begin
      if (first) begin
        self_hi <= dot_hi;
      end
      score <= (first ? dot_hi : self_hi) + dot_lo;
    end
    if (s1_vld) begin
      coef_o <= sat;
    end
  end

endmodule

// File: rtl/coef_fifo.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module coef_fifo import gat_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_i,
  input  coef_t din_i,
  input  logic  rd_i,
  output coef_t dout_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int DEPTH = `GAT_COEF_DEPTH;
  localparam int PW    = $clog2(DEPTH);

  coef_t         mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;

  assign empty_o = (count == '0);
  assign full_o  = (count == (PW+1)'(DEPTH));
  assign dout_o  = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_i, rd_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr] <= din_i;
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) wr_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) rd_i |-> !empty_o);

endmodule

// File: rtl/gat_layer.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module gat_layer import gat_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start_i,
  input  logic [`GAT_SG_W-1:0]                 num_sg_i,
  output logic [$clog2(`GAT_WEIGHT_DEPTH)-1:0] wgt_addr_o,
  input  data_t                                wgt_data_i,
  input  logic                                 wgt_load_done_i,
  output logic [`GAT_NODE_ADDR_W-1:0]          info_addr_o,
  input  node_info_t                           info_data_i,
  output logic [`GAT_H_ADDR_W-1:0]             h_addr_o,
  input  h_entry_t                             h_data_i,
  output logic                                 feat_vld_o,
  output feat_vec_t                            feat_o,
  output logic [`GAT_SG_W-1:0]                 feat_sg_o,
  output logic                                 done_o
);

  weight_mat_t weights;
  attn_vec_t   attn;
  logic        w_ready;
  wh_req_t     wh_req;
  wh_row_t     row;
  logic        row_vld;
  logic        row_last;
  logic        sg_done;
  logic        sg_bank;
  node_cnt_t   node_cnt;
  logic [1:0]  bank_busy;
  coef_t       coef_din;
  logic        coef_wr;
  coef_t       coef_dout;
  logic        coef_rd;
  logic        coef_empty;
  logic        coef_full;
  logic        rd_req;
  logic        rd_bank;
  slot_t       rd_slot;
  logic        rd_gnt;
  wh_row_t     rd_data;
  logic        bank_release;

  weight_loader u_weight_loader (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .wgt_load_done_i (wgt_load_done_i),
    .wgt_data_i      (wgt_data_i),
    .wgt_addr_o      (wgt_addr_o),
    .weights_o       (weights),
    .attn_o          (attn),
    .w_ready_o       (w_ready)
  );

  wh_engine u_wh_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_ready_i   (w_ready),
    .num_sg_i    (num_sg_i),
    .info_data_i (info_data_i),
    .h_data_i    (h_data_i),
    .weights_i   (weights),
    .bank_busy_i (bank_busy),
    .fifo_full_i (coef_full),
    .info_addr_o (info_addr_o),
    .h_addr_o    (h_addr_o),
    .wh_req_o    (wh_req),
    .row_o       (row),
    .row_vld_o   (row_vld),
    .row_last_o  (row_last),
    .sg_done_o   (sg_done),
    .sg_bank_o   (sg_bank),
    .node_cnt_o  (node_cnt)
  );

  coef_engine u_coef_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .attn_i     (attn),
    .row_i      (row),
    .row_vld_i  (row_vld),
    .row_last_i (row_last),
    .coef_o     (coef_din),
    .coef_wr_o  (coef_wr)
  );

  coef_fifo u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_wr),
    .din_i   (coef_din),
    .rd_i    (coef_rd),
    .dout_o  (coef_dout),
    .empty_o (coef_empty),
    .full_o  (coef_full)
  );

  wh_mem_arbiter u_wh_mem_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_req_i       (wh_req),
    .rd_req_i       (rd_req),
    .rd_bank_i      (rd_bank),
    .rd_slot_i      (rd_slot),
    .bank_release_i (bank_release),
    .rd_gnt_o       (rd_gnt),
    .rd_data_o      (rd_data),
    .bank_busy_o    (bank_busy)
  );

  aggregator u_aggregator (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .sg_done_i      (sg_done),
    .sg_bank_i      (sg_bank),
    .node_cnt_i     (node_cnt),
    .rd_gnt_i       (rd_gnt),
    .rd_data_i      (rd_data),
    .coef_i         (coef_dout),
    .coef_empty_i   (coef_empty),
    .num_sg_i       (num_sg_i),
    .rd_req_o       (rd_req),
    .rd_bank_o      (rd_bank),
    .rd_slot_o      (rd_slot),
    .coef_rd_o      (coef_rd),
    .bank_release_o (bank_release),
    .feat_o         (feat_o),
    .feat_vld_o     (feat_vld_o),
    .feat_sg_o      (feat_sg_o),
    .done_o         (done_o)
  );

endmodule

// File: rtl/gat_pkg.sv
`include "gat_defines.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0]       data_t;
  typedef logic signed [`GAT_WH_W-1:0]         wh_elem_t;
  typedef logic signed [`GAT_FEAT_W-1:0]       feat_t;
  typedef logic [$clog2(`GAT_MAX_NODES)-1:0]   slot_t;
  typedef logic [$clog2(`GAT_MAX_NODES+1)-1:0] node_cnt_t;

  typedef struct packed {
    data_t                 value;
    logic [`GAT_COL_W-1:0] col;
  } h_entry_t;

  typedef struct packed {
    logic [$clog2(`GAT_F_IN+1)-1:0] row_len;
    node_cnt_t                      node_cnt;
    logic                           last;
  } node_info_t;

  typedef data_t [`GAT_F_OUT-1:0][`GAT_F_IN-1:0] weight_mat_t;

  typedef struct packed {
    data_t [`GAT_F_OUT-1:0] a_hi;
    data_t [`GAT_F_OUT-1:0] a_lo;
  } attn_vec_t;

  typedef wh_elem_t [`GAT_F_OUT-1:0] wh_row_t;

  typedef struct packed {
    logic    valid;
    logic    bank;
    slot_t   slot;
    wh_row_t data;
  } wh_req_t;

  typedef logic signed [`GAT_DATA_W-1:0] coef_t;
  typedef feat_t [`GAT_F_OUT-1:0] feat_vec_t;

  typedef enum logic [1:0] {WH_IDLE, WH_INFO, WH_FETCH, WH_WRITE} wh_state_e;
  typedef enum logic [1:0] {AG_IDLE, AG_READ, AG_ACCUM, AG_EMIT} aggr_state_e;

endpackage

// File: rtl/weight_loader.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module weight_loader import gat_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start_i,
  input  logic                                 wgt_load_done_i,
  input  data_t                                wgt_data_i,
  output logic [$clog2(`GAT_WEIGHT_DEPTH)-1:0] wgt_addr_o,
  output weight_mat_t                          weights_o,
  output attn_vec_t                            attn_o,
  output logic                                 w_ready_o
);

  localparam int AW      = $clog2(`GAT_WEIGHT_DEPTH);
  localparam int IW      = $clog2(`GAT_F_IN);
  localparam int OW      = $clog2(`GAT_F_OUT);
  localparam int W_WORDS = `GAT_F_IN * `GAT_F_OUT;

  logic          active;
  logic          ret_vld;
  logic [AW-1:0] ret_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active     <= 1'b0;
      ret_vld    <= 1'b0;
      ret_addr   <= '0;
      wgt_addr_o <= '0;
      w_ready_o  <= 1'b0;
    end else begin
      ret_vld  <= active;
      ret_addr <= wgt_addr_o;
      if (!start_i) begin
        active     <= 1'b0;
        wgt_addr_o <= '0;
        w_ready_o  <= 1'b0;
      end else if (active) begin
        // One address per cycle, stop after the last word
        if (wgt_addr_o == AW'(`GAT_WEIGHT_DEPTH - 1)) begin
          active     <= 1'b0;
          wgt_addr_o <= '0;
        end else begin
          wgt_addr_o <= wgt_addr_o + 1'b1;
        end
      end else if (ret_vld) begin
        w_ready_o <= 1'b1;
      end else if (!w_ready_o && wgt_load_done_i) begin
        active <= 1'b1;
      end
    end
  end

  // Returned word lands one cycle behind its address
  always_ff @(posedge clk) begin
    if (ret_vld) begin
      if (ret_addr < AW'(W_WORDS)) begin
        weights_o[ret_addr[IW+OW-1:IW]][ret_addr[IW-1:0]] <= wgt_data_i;
      end else if (ret_addr < AW'(W_WORDS + `GAT_F_OUT)) begin
        attn_o.a_hi[ret_addr[OW-1:0]] <= wgt_data_i;
      end else begin
        attn_o.a_lo[ret_addr[OW-1:0]] <= wgt_data_i;
      end
    end
  end

endmodule

// File: rtl/wh_engine.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module wh_engine import gat_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        w_ready_i,
  input  logic [`GAT_SG_W-1:0]        num_sg_i,
  input  node_info_t                  info_data_i,
  input  h_entry_t                    h_data_i,
  input  weight_mat_t                 weights_i,
  input  logic [1:0]                  bank_busy_i,
  input  logic                        fifo_full_i,
  output logic [`GAT_NODE_ADDR_W-1:0] info_addr_o,
  output logic [`GAT_H_ADDR_W-1:0]    h_addr_o,
  output wh_req_t                     wh_req_o,
  output wh_row_t                     row_o,
  output logic                        row_vld_o,
  output logic                        row_last_o,
  output logic                        sg_done_o,
  output logic                        sg_bank_o,
  output node_cnt_t                   node_cnt_o
);

  wh_state_e                          state;
  logic                               info_phase;
  node_info_t                         info;
  logic [$clog2(`GAT_F_IN+1)-1:0]     ent;
  slot_t                              slot;
  logic                               bank;
  logic [`GAT_SG_W-1:0]               sg_cnt;
  logic                               fin;
  logic                               wr_go;
  wh_row_t                            acc;
  logic signed [2*`GAT_DATA_W-1:0]    prod [`GAT_F_OUT];

  // First row of a subgraph needs a free bank
  assign wr_go = (state == WH_WRITE) && !fifo_full_i &&
                 !((slot == '0) && bank_busy_i[bank]);

  always_comb begin
    for (int o = 0; o < `GAT_F_OUT; o++) begin
      prod[o] = $signed(h_data_i.value) * $signed(weights_i[o][h_data_i.col]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= WH_IDLE;
      info_phase  <= 1'b0;
      ent         <= '0;
      slot        <= '0;
      bank        <= 1'b0;
      sg_cnt      <= '0;
      fin         <= 1'b0;
      info_addr_o <= '0;
      h_addr_o    <= '0;
    end else begin
      case (state)
        WH_IDLE: begin
          if (!w_ready_i) begin
            fin         <= 1'b0;
            sg_cnt      <= '0;
            bank        <= 1'b0;
            info_addr_o <= '0;
            h_addr_o    <= '0;
          end else if (!fin && (num_sg_i != '0)) begin
            state <= WH_INFO;
          end
        end
        WH_INFO: begin
          info_phase <= !info_phase;
          if (info_phase) begin
            ent   <= '0;
            state <= WH_FETCH;
          end
        end
        WH_FETCH: begin
          // Addresses on 0..len-1, data one cycle later
          ent <= ent + 1'b1;
          if (ent == info.row_len) begin
            state <= WH_WRITE;
          end else begin
            h_addr_o <= h_addr_o + 1'b1;
          end
        end
        WH_WRITE: begin
          if (wr_go) begin
            info_addr_o <= info_addr_o + 1'b1;
            if (info.last) begin
              slot   <= '0;
              bank   <= !bank;
              sg_cnt <= sg_cnt + 1'b1;
              if (sg_cnt + 1'b1 == num_sg_i) begin
                fin   <= 1'b1;
                state <= WH_IDLE;
              end else begin
                state <= WH_INFO;
              end
            end else begin
              slot  <= slot + 1'b1;
              state <= WH_INFO;
            end
          end
        end
        default: state <= WH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == WH_INFO) && info_phase) begin
      info <= info_data_i;
    end
    if (state == WH_INFO) begin
      acc <= '0;
    end else if ((state == WH_FETCH) && (ent != '0)) begin
      for (int o = 0; o < `GAT_F_OUT; o++) begin
        acc[o] <= $signed(acc[o]) + prod[o];
      end
    end
  end

  assign wh_req_o.valid = wr_go;
  assign wh_req_o.bank  = bank;
  assign wh_req_o.slot  = slot;
  assign wh_req_o.data  = acc;
  assign row_o          = acc;
  assign row_vld_o      = wr_go;
  assign row_last_o     = info.last;
  assign sg_done_o      = wr_go && info.last;
  assign sg_bank_o      = bank;
  assign node_cnt_o     = info.node_cnt;

  a_row_len : assert property (@(posedge clk) disable iff (!rst_n)
    (state == WH_FETCH) |-> (info.row_len <= `GAT_F_IN));

  // Node count in the info word agrees with the rows written
  a_node_cnt : assert property (@(posedge clk) disable iff (!rst_n)
    sg_done_o |-> (node_cnt_o == slot + 1'b1));

endmodule

// File: rtl/wh_mem_arbiter.sv
`timescale 1ns/100ps
`include "gat_defines.svh"

module wh_mem_arbiter import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  wh_req_t    wr_req_i,
  input  logic       rd_req_i,
  input  logic       rd_bank_i,
  input  slot_t      rd_slot_i,
  input  logic       bank_release_i,
  output logic       rd_gnt_o,
  output wh_row_t    rd_data_o,
  output logic [1:0] bank_busy_o
);

  wh_row_t mem [2*`GAT_MAX_NODES];

  // Writer has fixed priority, a losing read retries
  assign rd_gnt_o = rd_req_i && !wr_req_i.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bank_busy_o <= 2'b00;
    end else begin
      if (bank_release_i) begin
        bank_busy_o[rd_bank_i] <= 1'b0;
      end
      if (wr_req_i.valid) begin
        bank_busy_o[wr_req_i.bank] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req_i.valid) begin
      mem[{wr_req_i.bank, wr_req_i.slot}] <= wr_req_i.data;
    end
    if (rd_gnt_o) begin
      rd_data_o <= mem[{rd_bank_i, rd_slot_i}];
    end
  end

  // Reads only hit a filled bank
  a_rd_gnt : assert property (@(posedge clk) disable iff (!rst_n)
    rd_gnt_o |-> bank_busy_o[rd_bank_i]);

  a_bank_free : assert property (@(posedge clk) disable iff (!rst_n)
    (wr_req_i.valid && (wr_req_i.slot == '0)) |-> !bank_busy_o[wr_req_i.bank]);

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module gat_layer_tb -f gat_layer.f -o gat_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/gat_sim > sim.log 2>&1; cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
